//--- logic/ttc_pkg.sv
/*
  ttc broadcast subsystem package
  command and fill codes, widths, register map and the shared structs
*/
`default_nettype none

package ttc_pkg;

  // counter widths of the tagger
  localparam int trig_num_w = 24;
  localparam int ts_w = 40;

  // fill type carried in broadcast bits 7 to 3
  typedef logic [4:0] fill_t;

  localparam fill_t fill_muon     = 5'd1;
  localparam fill_t fill_laser    = 5'd2;
  localparam fill_t fill_pedestal = 5'd3;
  localparam fill_t fill_async    = 5'd4;

  // broadcast bits 7 to 2 of the timestamp reset command
  localparam logic [5:0] cmd_timestamp_reset = 6'b001010;

  // one broadcast strobe from the channel b decoder
  typedef struct packed {
    logic       valid;
    logic [5:0] info;
  } chan_b_cmd_t;

  // receiver to tagger
  typedef struct packed {
    fill_t fill_type;
    logic  accept_pulse_triggers;
    logic  reset_trig_num;
    logic  reset_trig_timestamp;
  } trig_ctrl_t;

  // receiver to register block
  typedef struct packed {
    fill_t       fill_type;
    logic        accept_pulse_triggers;
    logic [31:0] unknown_cmd_count;
    logic        error_unknown_ttc;
  } rx_status_t;

  // one tagged trigger, valid for a single cycle
  typedef struct packed {
    logic                  valid;
    logic [trig_num_w-1:0] trig_num;
    logic [ts_w-1:0]       timestamp;
    fill_t                 fill_type;
  } trig_record_t;

  // register map
  typedef logic [2:0] reg_addr_t;

  localparam reg_addr_t reg_ctrl          = 3'd0;
  localparam reg_addr_t reg_threshold     = 3'd1;
  localparam reg_addr_t reg_unknown_count = 3'd2;
  localparam reg_addr_t reg_status        = 3'd3;

  typedef struct packed {
    logic        wr;
    logic        rd;
    reg_addr_t   addr;
    logic [31:0] wdata;
  } reg_req_t;

endpackage

`default_nettype wire

//--- logic/ttc_broadcast_receiver.sv
/*
  ttc channel b broadcast receiver
  decodes command strobes into fill type, pulse storage enable and resets
*/
`default_nettype none

module ttc_broadcast_receiver (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ttc_pkg::chan_b_cmd_t chan_b,
  input  logic                 evt_count_reset,
  input  logic                 loopback,
  input  logic [31:0]          threshold,
  output ttc_pkg::trig_ctrl_t  trig_ctrl,
  output ttc_pkg::rx_status_t  rx_status
);

  import ttc_pkg::*;

  // command set, broadcast bits 7..3 / 2 / 1..0
  //   xxxxx_1_00  fill type switch, bits 7..3 give the type
  //   00101_0_00  timestamp reset
  //   11000_0_00  start async pulse storage
  //   10000_0_00  stop async pulse storage
  //   00000_0_10  event count reset, seen on evt_count_reset

  fill_t       fill_type_q;
  fill_t       fill_type_d;
  logic        accept_q;
  logic        accept_d;
  logic [31:0] unknown_q;
  logic [31:0] unknown_d;
  logic        ts_reset;
  logic        clear;

  // zero latency pulses
  assign ts_reset = chan_b.valid && (chan_b.info == cmd_timestamp_reset);

  // loopback holds the receiver in its cleared state
  assign clear = !rst_n || loopback;

  // next state, priority as in the command table
  always_comb begin
    fill_type_d = fill_type_q;
    accept_d    = accept_q;
    unknown_d   = unknown_q;
    if (chan_b.valid && chan_b.info[0]) begin
      fill_type_d = chan_b.info[5:1];
    end else if (chan_b.valid && chan_b.info[5] && (chan_b.info[3:0] == 4'b0000)) begin
      // bit 4 selects start or stop
      accept_d = chan_b.info[4];
    end else if (chan_b.valid && !evt_count_reset && !ts_reset) begin
      // nothing matched, soft error
      unknown_d = unknown_q + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (clear) begin
      fill_type_q <= fill_muon;
      accept_q    <= 1'b0;
      unknown_q   <= 32'd0;
    end else begin
      fill_type_q <= fill_type_d;
      accept_q    <= accept_d;
      unknown_q   <= unknown_d;
    end
  end

  // towards the tagger
  assign trig_ctrl.fill_type             = fill_type_q;
  assign trig_ctrl.accept_pulse_triggers = accept_q;
  assign trig_ctrl.reset_trig_num        = evt_count_reset;
  assign trig_ctrl.reset_trig_timestamp  = ts_reset;

  // towards the register block
  assign rx_status.fill_type             = fill_type_q;
  assign rx_status.accept_pulse_triggers = accept_q;
  assign rx_status.unknown_cmd_count     = unknown_q;
  assign rx_status.error_unknown_ttc     = (unknown_q > threshold);

  // soft error count only falls through a clear
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && !$past(loopback) |-> unknown_q >= $past(unknown_q))
    else $error("unknown command count decreased without a clear");

  // fill type moves only on a fill command or a clear
  assert property (@(posedge clk) disable iff (!rst_n)
    $changed(fill_type_q) |->
      $past(chan_b.valid && chan_b.info[0]) || $past(clear))
    else $error("fill type changed without a fill command");

endmodule

`default_nettype wire

//--- logic/ttc_trigger_tagger.sv
/*
  trigger tagger
  timestamp and trigger number counters, emits one record per accepted trigger
*/
`default_nettype none

module ttc_trigger_tagger (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  trigger,
  input  ttc_pkg::trig_ctrl_t   trig_ctrl,
  output ttc_pkg::trig_record_t trig_record
);

  import ttc_pkg::*;

  logic [ts_w-1:0]       timestamp;
  logic [trig_num_w-1:0] trig_num;
  logic [trig_num_w-1:0] trig_num_inc;
  logic                  accept;

  // record payload
  logic                  rec_valid;
  logic [trig_num_w-1:0] rec_num;
  logic [ts_w-1:0]       rec_ts;
  fill_t                 rec_fill;

  // async fill drops triggers unless pulse storage is on
  assign accept = trigger &&
                  ((trig_ctrl.fill_type != fill_async) || trig_ctrl.accept_pulse_triggers);

  // first trigger after a reset is numbered 1
  assign trig_num_inc = trig_num + 1'b1;

  // free running timestamp, reads 0 the cycle after a reset command
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timestamp <= '0;
    end else if (trig_ctrl.reset_trig_timestamp) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + 1'b1;
    end
  end

  // trigger number, the reset level wins over a trigger
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trig_num <= '0;
    end else if (trig_ctrl.reset_trig_num) begin
      trig_num <= '0;
    end else if (accept) begin
      trig_num <= trig_num_inc;
    end
  end

  // one cycle strobe, back to back triggers give back to back records
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= accept;
    end
  end

  // payload captured with the trigger cycle values
  always_ff @(posedge clk) begin
    if (accept) begin
      rec_num  <= trig_num_inc;
      rec_ts   <= timestamp;
      rec_fill <= trig_ctrl.fill_type;
    end
  end

  assign trig_record.valid     = rec_valid;
  assign trig_record.trig_num  = rec_num;
  assign trig_record.timestamp = rec_ts;
  assign trig_record.fill_type = rec_fill;

  // every record traces back to a trigger one cycle earlier
  assert property (@(posedge clk) disable iff (!rst_n)
    trig_record.valid |-> $past(trigger))
    else $error("record emitted without a trigger");

endmodule

`default_nettype wire

//--- logic/ttc_status_regs.sv
/*
  status register block
  loopback and threshold control, read back of receiver status and counters
*/
`default_nettype none

module ttc_status_regs #(
  parameter logic [31:0] reset_threshold = 32'd3
) (
  input  logic                clk,
  input  logic                rst_n,
  input  ttc_pkg::reg_req_t   reg_req,
  input  ttc_pkg::rx_status_t rx_status,
  output logic                loopback,
  output logic [31:0]         threshold,
  output logic [31:0]         reg_rdata,
  output logic                reg_rvalid
);

  import ttc_pkg::*;

  logic [31:0] rd_mux;
  logic [31:0] status_word;

  // status layout: error, pulse storage, fill type
  assign status_word = {25'd0,
                        rx_status.error_unknown_ttc,
                        rx_status.accept_pulse_triggers,
                        rx_status.fill_type};

  // writable registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      loopback  <= 1'b0;
      threshold <= reset_threshold;
    end else if (reg_req.wr) begin
      case (reg_req.addr)
        reg_ctrl: begin
          loopback <= reg_req.wdata[0];
        end
        reg_threshold: begin
          threshold <= reg_req.wdata;
        end
        // count and status are read only
        default: begin
        end
      endcase
    end
  end

  // read select
  always_comb begin
    case (reg_req.addr)
      reg_ctrl: begin
        rd_mux = {31'd0, loopback};
      end
      reg_threshold: begin
        rd_mux = threshold;
      end
      reg_unknown_count: begin
        rd_mux = rx_status.unknown_cmd_count;
      end
      reg_status: begin
        rd_mux = status_word;
      end
      default: begin
        rd_mux = 32'd0;
      end
    endcase
  end

  // response one cycle after the read strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_req.rd;
    end
  end

  // value as sampled in the read cycle
  always_ff @(posedge clk) begin
    if (reg_req.rd) begin
      reg_rdata <= rd_mux;
    end
  end

  // the port carries one access per cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(reg_req.wr && reg_req.rd))
    else $error("register write and read in the same cycle");

endmodule

`default_nettype wire

//--- logic/ttc_rx_top.sv
/*
  ttc broadcast subsystem top
  connects receiver, register block and trigger tagger
*/
`default_nettype none

module ttc_rx_top #(
  parameter logic [31:0] reset_threshold = 32'd3
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // channel b side
  input  ttc_pkg::chan_b_cmd_t  chan_b,
  input  logic                  evt_count_reset,
  input  logic                  trigger,

  // register port
  input  ttc_pkg::reg_req_t     reg_req,
  output logic [31:0]           reg_rdata,
  output logic                  reg_rvalid,

  // trigger logic side
  output ttc_pkg::trig_record_t trig_record,
  output logic                  error_unknown_ttc
);

  import ttc_pkg::*;

  trig_ctrl_t  trig_ctrl;
  rx_status_t  rx_status;
  logic        loopback;
  logic [31:0] threshold;

  // hard error flag straight from the receiver
  assign error_unknown_ttc = rx_status.error_unknown_ttc;

  ttc_broadcast_receiver u_receiver (
    .clk             (clk),
    .rst_n           (rst_n),
    .chan_b          (chan_b),
    .evt_count_reset (evt_count_reset),
    .loopback        (loopback),
    .threshold       (threshold),
    .trig_ctrl       (trig_ctrl),
    .rx_status       (rx_status)
  );

  // steers the receiver through loopback and threshold
  ttc_status_regs #(
    .reset_threshold (reset_threshold)
  ) u_status_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_req    (reg_req),
    .rx_status  (rx_status),
    .loopback   (loopback),
    .threshold  (threshold),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid)
  );

  ttc_trigger_tagger u_tagger (
    .clk         (clk),
    .rst_n       (rst_n),
    .trigger     (trigger),
    .trig_ctrl   (trig_ctrl),
    .trig_record (trig_record)
  );

endmodule

`default_nettype wire

//--- bench/ttc_clk_gen.sv
/*
  testbench clock and reset generator
*/
`default_nettype none

module ttc_clk_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/ttc_rx_tb.sv
/*
  testbench for the ttc broadcast subsystem
  replays the case file against a cycle model of receiver, tagger and registers
*/
`default_nettype none

module ttc_rx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ttc_pkg::*;

  localparam int max_cases = 128;

  logic         clk;
  logic         rst_n;
  chan_b_cmd_t  chan_b;
  logic         evt_count_reset;
  logic         trigger;
  reg_req_t     reg_req;
  logic [31:0]  reg_rdata;
  logic         reg_rvalid;
  trig_record_t trig_record;
  logic         error_unknown_ttc;

  // reference model state
  fill_t                 m_fill;
  logic                  m_accept;
  logic [31:0]           m_unknown;
  logic [31:0]           m_threshold;
  logic                  m_loopback;
  logic [ts_w-1:0]       m_ts;
  logic [trig_num_w-1:0] m_trig_num;
  logic                  m_rec_valid;
  logic [trig_num_w-1:0] m_rec_num;
  logic [ts_w-1:0]       m_rec_ts;
  fill_t                 m_rec_fill;
  logic                  m_rvalid;
  logic [31:0]           m_rdata;

  // cases as read from the file
  logic [2:0]  case_op [max_cases];
  logic [31:0] case_a  [max_cases];
  logic [31:0] case_b  [max_cases];
  logic [31:0] case_e  [max_cases];
  int          n_cases;
  logic        cases_loaded;
  int unsigned gap;

  ttc_clk_gen #(.period_ns(4), .reset_cycles(8)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  ttc_rx_top #(.reset_threshold(32'd3)) u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .chan_b            (chan_b),
    .evt_count_reset   (evt_count_reset),
    .trigger           (trigger),
    .reg_req           (reg_req),
    .reg_rdata         (reg_rdata),
    .reg_rvalid        (reg_rvalid),
    .trig_record       (trig_record),
    .error_unknown_ttc (error_unknown_ttc)
  );

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic logic [2:0] op_code(input logic [63:0] tok);
    if (tok == 64'("cmd")) return 3'd0;
    if (tok == 64'("evt")) return 3'd1;
    if (tok == 64'("trig")) return 3'd2;
    if (tok == 64'("wr")) return 3'd3;
    if (tok == 64'("rd")) return 3'd4;
    return 3'd7;
  endfunction

  task automatic read_cases();
    int               fd;
    int               code;
    logic [63:0]      tok;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      e;
    logic [8*160-1:0] rest;
    fd = $fopen("bench/ttc_rx_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file bench/ttc_rx_cases.txt");
      $display("Regression failed");
      $fatal(1, "no stimulus");
    end
    n_cases = 0;
    code = 1;
    while (code == 1) begin
      tok = '0;
      code = $fscanf(fd, "%s", tok);
      if (code == 1 && tok == 64'("#")) begin
        // comment, drop the rest of the line
        void'($fgets(rest, fd));
      end else if (code == 1) begin
        if ($fscanf(fd, "%h %h %h", a, b, e) != 3 || op_code(tok) == 3'd7 ||
            n_cases == max_cases) begin
          $display("case file line %0d could not be understood", n_cases + 1);
          $display("Regression failed");
          $fatal(1, "bad case file");
        end
        case_op[n_cases] = op_code(tok);
        case_a[n_cases]  = a;
        case_b[n_cases]  = b;
        case_e[n_cases]  = e;
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  // one clock of stimulus, model update and output compare
  task automatic run_cycle(input logic cv, input logic [5:0] info, input logic evt,
                           input logic trig, input logic wr, input logic rd,
                           input reg_addr_t addr, input logic [31:0] wdata);
    logic        accepted;
    logic [31:0] status;
    chan_b.valid    = cv;
    chan_b.info     = info;
    evt_count_reset = evt;
    trigger         = trig;
    reg_req.wr      = wr;
    reg_req.rd      = rd;
    reg_req.addr    = addr;
    reg_req.wdata   = wdata;
    @(posedge clk);
    // model sees the state before this edge
    accepted = trig && ((m_fill != fill_async) || m_accept);
    status = {25'd0, m_unknown > m_threshold, m_accept, m_fill};
    m_rec_valid = accepted;
    if (accepted) begin
      m_rec_num  = m_trig_num + 24'd1;
      m_rec_ts   = m_ts;
      m_rec_fill = m_fill;
    end
    m_trig_num = evt ? '0 : (accepted ? m_trig_num + 24'd1 : m_trig_num);
    m_ts = (cv && info == cmd_timestamp_reset) ? '0 : m_ts + 40'd1;
    m_rvalid = rd;
    if (rd) begin
      case (addr)
        reg_ctrl:          m_rdata = {31'd0, m_loopback};
        reg_threshold:     m_rdata = m_threshold;
        reg_unknown_count: m_rdata = m_unknown;
        reg_status:        m_rdata = status;
        default:           m_rdata = '0;
      endcase
    end
    // decode priority, loopback holds everything cleared
    if (m_loopback) begin
      m_fill    = fill_muon;
      m_accept  = 1'b0;
      m_unknown = '0;
    end else if (cv && info[0]) begin
      m_fill = info[5:1];
    end else if (cv && info[5] && info[3:0] == 4'd0) begin
      m_accept = info[4];
    end else if (cv && !evt && info != cmd_timestamp_reset) begin
      m_unknown = m_unknown + 32'd1;
    end
    // writes land after the receiver used the old loopback
    if (wr && addr == reg_ctrl) m_loopback = wdata[0];
    if (wr && addr == reg_threshold) m_threshold = wdata;
    @(negedge clk);
    check_value(64'(trig_record.valid), 64'(m_rec_valid), "record valid");
    if (m_rec_valid) begin
      check_value(64'(trig_record.trig_num), 64'(m_rec_num), "record trigger number");
      check_value(64'(trig_record.timestamp), 64'(m_rec_ts), "record timestamp");
      check_value(64'(trig_record.fill_type), 64'(m_rec_fill), "record fill type");
    end
    check_value(64'(reg_rvalid), 64'(m_rvalid), "read valid");
    if (m_rvalid) check_value(64'(reg_rdata), 64'(m_rdata), "read data");
    check_value(64'(error_unknown_ttc), 64'(m_unknown > m_threshold), "error flag");
  endtask

  task automatic run_case(input int i);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] e;
    a = case_a[i];
    b = case_b[i];
    e = case_e[i];
    case (case_op[i])
      3'd0: begin
        run_cycle(1'b1, a[5:0], 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 32'd0);
        check_value(64'(error_unknown_ttc), 64'(e), "error flag after command");
      end
      3'd1: begin
        run_cycle(b[0], a[5:0], 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 32'd0);
        check_value(64'(error_unknown_ttc), 64'(e), "error flag after event reset");
      end
      3'd2: begin
        run_cycle(1'b0, 6'd0, 1'b0, 1'b1, 1'b0, 1'b0, 3'd0, 32'd0);
        check_value(64'(trig_record.valid), 64'(e), "record from case file");
      end
      3'd3: begin
        run_cycle(1'b0, 6'd0, 1'b0, 1'b0, 1'b1, 1'b0, a[2:0], b);
      end
      default: begin
        run_cycle(1'b0, 6'd0, 1'b0, 1'b0, 1'b0, 1'b1, a[2:0], 32'd0);
        check_value(64'(reg_rdata), 64'(e), "read data from case file");
      end
    endcase
  endtask

  initial begin
    chan_b          = '0;
    evt_count_reset = 1'b0;
    trigger         = 1'b0;
    reg_req         = '0;
    cases_loaded    = 1'b0;
    void'($urandom(9));
    // model state right after reset
    m_fill      = fill_muon;
    m_accept    = 1'b0;
    m_unknown   = '0;
    m_threshold = 32'd3;
    m_loopback  = 1'b0;
    m_ts        = '0;
    m_trig_num  = '0;
    m_rec_valid = 1'b0;
    m_rvalid    = 1'b0;
    read_cases();
    cases_loaded = 1'b1;
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
      // short idle gap between cases
      gap = $urandom % 3;
      repeat (gap) run_cycle(1'b0, 6'd0, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 32'd0);
    end
    $display("Regression passed");
    $finish;
  end

  // watchdog scaled by the number of cases
  initial begin
    wait (cases_loaded === 1'b1);
    repeat ((n_cases + 50) * 40) @(posedge clk);
    $display("timeout: the cases did not finish within %0d cycles", (n_cases + 50) * 40);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- ttc_rx_top.f
logic/ttc_pkg.sv
logic/ttc_broadcast_receiver.sv
logic/ttc_trigger_tagger.sv
logic/ttc_status_regs.sv
logic/ttc_rx_top.sv
bench/ttc_clk_gen.sv
bench/ttc_rx_tb.sv

//--- Makefile
# verilator build and regression run for the ttc broadcast subsystem
VERILATOR ?= verilator
TOP       ?= ttc_rx_tb
RTL_TOP   ?= ttc_rx_top
FILELIST  ?= ttc_rx_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/ttc_rx_cases.txt
# op a b expect (hex); cmd/evt: a=info, b=strobe on evt, expect=error flag
# trig: expect=record; wr: a=addr, b=data; rd: a=addr, expect=read data
rd 3 0 01
rd 1 0 03
trig 0 0 1
trig 0 0 1
trig 0 0 1
evt 00 0 0
trig 0 0 1
cmd 0a 0 0
trig 0 0 1
cmd 05 0 0
rd 3 0 02
trig 0 0 1
cmd 07 0 0
rd 3 0 03
cmd 09 0 0
rd 3 0 04
trig 0 0 0
cmd 30 0 0
rd 3 0 24
trig 0 0 1
trig 0 0 1
cmd 20 0 0
trig 0 0 0
cmd 03 0 0
wr 1 2 0
rd 1 0 02
cmd 02 0 0
evt 00 1 0
cmd 04 0 0
cmd 3e 0 1
rd 2 0 03
rd 3 0 41
cmd 07 0 1
wr 0 1 0
rd 0 0 01
rd 2 0 00
cmd 05 0 0
rd 3 0 01
wr 0 0 0
cmd 05 0 0
rd 3 0 02
trig 0 0 1
